//--- rv32i_backend.f
rv32i_pkg.sv
rv32i_ctrl.sv
rv32i_regfile.sv
rv32i_stage_reg.sv
rv32i_execute.sv
rv32i_mem_stage.sv
rv32i_data_mem.sv
rv32i_writeback.sv
rv32i_backend.sv
tb_rv32i_checker.sv
tb_rv32i_backend.sv

//--- rv32i_backend.sv
`timescale 1ns/10ps

module rv32i_backend (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  instr_valid_i,
   input  rv32i_pkg::rv32i_word  instr_i,
   input  rv32i_pkg::rv32i_word  pc_i,
   output rv32i_pkg::pcmux_sel_t pcmux_sel_o,
   output rv32i_pkg::rv32i_word  br_target_o,
   output logic                  dmem_write_o,
   output rv32i_pkg::rv32i_word  dmem_addr_o,
   output rv32i_pkg::rv32i_word  dmem_wdata_o,
   output logic                  wb_valid_o,
   output logic [4:0]            wb_rd_o,
   output rv32i_pkg::rv32i_word  wb_data_o
);
   import rv32i_pkg::*;

   rv32i_control_word ctrl;
   rv32i_word         imm;
   rv32i_word         rs1_data;
   rv32i_word         rs2_data;
   id_ex_t            id_ex_d;
   id_ex_t            id_ex_q;
   ex_mem_t           ex_mem_d;
   ex_mem_t           ex_mem_q;
   mem_wb_t           mem_wb_d;
   mem_wb_t           mem_wb_q;
   logic              dmem_read;
   rv32i_word         dmem_rdata;

   // ##########################################################
   // register read
   rv32i_ctrl u_ctrl (
      .clk     (clk),
      .rst_i   (rst_i),
      .valid_i (instr_valid_i),
      .instr_i (instr_i),
      .ctrl_o  (ctrl),
      .imm_o   (imm)
   );

   rv32i_regfile u_regfile (
      .clk        (clk),
      .rst_i      (rst_i),
      .we_i       (wb_valid_o),
      .rd_i       (wb_rd_o),
      .rd_data_i  (wb_data_o),
      .rs1_i      (instr_i[19:15]),
      .rs2_i      (instr_i[24:20]),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   assign id_ex_d = '{valid: instr_valid_i, pc: pc_i, instr: instr_i, ctrl: ctrl,
                      imm: imm, rs1_out: rs1_data, rs2_out: rs2_data};

   rv32i_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
      .clk   (clk),
      .rst_i (rst_i),
      .d_i   (id_ex_d),
      .q_o   (id_ex_q)
   );

   // ##########################################################
   // execute and memory
   rv32i_execute u_execute (
      .id_ex_i  (id_ex_q),
      .ex_mem_o (ex_mem_d)
   );

   rv32i_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
      .clk   (clk),
      .rst_i (rst_i),
      .d_i   (ex_mem_d),
      .q_o   (ex_mem_q)
   );

   rv32i_mem_stage u_mem_stage (
      .clk          (clk),
      .rst_i        (rst_i),
      .ex_mem_i     (ex_mem_q),
      .mem_wb_o     (mem_wb_d),
      .pcmux_sel_o  (pcmux_sel_o),
      .br_target_o  (br_target_o),
      .dmem_read_o  (dmem_read),
      .dmem_write_o (dmem_write_o),
      .dmem_addr_o  (dmem_addr_o),
      .dmem_wdata_o (dmem_wdata_o)
   );

   rv32i_data_mem u_data_mem (
      .clk     (clk),
      .read_i  (dmem_read),
      .write_i (dmem_write_o),
      .addr_i  (dmem_addr_o),
      .wdata_i (dmem_wdata_o),
      .rdata_o (dmem_rdata)
   );

   rv32i_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
      .clk   (clk),
      .rst_i (rst_i),
      .d_i   (mem_wb_d),
      .q_o   (mem_wb_q)
   );

   // ##########################################################
   // writeback
   rv32i_writeback u_writeback (
      .clk      (clk),
      .rst_i    (rst_i),
      .mem_wb_i (mem_wb_q),
      .rdata_i  (dmem_rdata),
      .we_o     (wb_valid_o),
      .rd_o     (wb_rd_o),
      .data_o   (wb_data_o)
   );

endmodule : rv32i_backend

//--- rv32i_ctrl.sv
`timescale 1ns/10ps

module rv32i_ctrl (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         valid_i,
   input  rv32i_pkg::rv32i_word         instr_i,
   output rv32i_pkg::rv32i_control_word ctrl_o,
   output rv32i_pkg::rv32i_word         imm_o
);
   import rv32i_pkg::*;

   rv32i_opcode opcode;
   logic [2:0]  funct3;
   rv32i_word   i_imm;
   rv32i_word   s_imm;
   rv32i_word   b_imm;
   rv32i_word   u_imm;

   assign opcode = rv32i_opcode'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];

   assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
   assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
   assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
   assign u_imm = {instr_i[31:12], 12'h000};

   always_comb begin
      ctrl_o                = '0;
      ctrl_o.opcode         = opcode;
      ctrl_o.rd             = instr_i[11:7];
      ctrl_o.aluop          = alu_add;
      ctrl_o.cmpop          = beq;
      ctrl_o.alumux1_sel    = alumux1_rs1;
      ctrl_o.alumux2_sel    = alumux2_imm;
      ctrl_o.marmux_sel     = marmux_pc;
      ctrl_o.regfilemux_sel = rf_alu_out;
      imm_o                 = i_imm;
      case (opcode)
         op_lui: begin
            ctrl_o.regfilemux_sel = rf_imm;
            ctrl_o.load_regfile   = 1'b1;
            imm_o                 = u_imm;
         end
         op_auipc: begin
            ctrl_o.alumux1_sel  = alumux1_pc;
            ctrl_o.load_regfile = 1'b1;
            imm_o               = u_imm;
         end
         op_br: begin
            ctrl_o.alumux1_sel = alumux1_pc;
            ctrl_o.cmpop       = branch_funct3_t'(funct3);
            imm_o              = b_imm;
         end
         op_load: begin
            ctrl_o.marmux_sel     = marmux_alu_out;
            ctrl_o.mem_read       = 1'b1;
            ctrl_o.regfilemux_sel = rf_rdata;
            ctrl_o.load_regfile   = 1'b1;
         end
         op_store: begin
            ctrl_o.marmux_sel = marmux_alu_out;
            ctrl_o.mem_write  = 1'b1;
            imm_o             = s_imm;
         end
         op_imm, op_reg: begin
            ctrl_o.load_regfile = 1'b1;
            ctrl_o.aluop        = alu_ops'(funct3);
            if (opcode == op_reg) begin
               ctrl_o.alumux2_sel = alumux2_rs2;
            end
            case (funct3)
               3'b000: ctrl_o.aluop = (opcode == op_reg && instr_i[30]) ? alu_sub : alu_add;
               // slt and sltu come from the comparator
               3'b010: ctrl_o.cmpop = blt;
               3'b011: ctrl_o.cmpop = bltu;
               3'b101: ctrl_o.aluop = instr_i[30] ? alu_sra : alu_srl;
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   known_opcode_a: assert property (@(posedge clk) disable iff (rst_i)
      valid_i |-> instr_i[6:0] inside {op_lui, op_auipc, op_br, op_load,
                                       op_store, op_imm, op_reg});

endmodule : rv32i_ctrl

//--- rv32i_data_mem.sv
`timescale 1ns/10ps

module rv32i_data_mem (
   input  logic                 clk,
   input  logic                 read_i,
   input  logic                 write_i,
   input  rv32i_pkg::rv32i_word addr_i,
   input  rv32i_pkg::rv32i_word wdata_i,
   output rv32i_pkg::rv32i_word rdata_o
);
   import rv32i_pkg::*;

   rv32i_word             mem [dmem_words];
   logic [dmem_aw-1:0]    idx;

   // word addressed, low two bits dropped
   assign idx = addr_i[dmem_aw+1:2];

   always_ff @(posedge clk) begin
      if (write_i) begin
         mem[idx] <= wdata_i;
      end
      if (read_i) begin
         rdata_o <= mem[idx];
      end
   end

endmodule : rv32i_data_mem

//--- rv32i_execute.sv
`timescale 1ns/10ps

module rv32i_execute (
   input  rv32i_pkg::id_ex_t  id_ex_i,
   output rv32i_pkg::ex_mem_t ex_mem_o
);
   import rv32i_pkg::*;

   rv32i_word opa;
   rv32i_word opb;
   rv32i_word cmp_b;
   rv32i_word alu_res;
   logic      br_en;
   logic      set_less;

   assign opa   = (id_ex_i.ctrl.alumux1_sel == alumux1_pc) ? id_ex_i.pc : id_ex_i.rs1_out;
   assign opb   = (id_ex_i.ctrl.alumux2_sel == alumux2_imm) ? id_ex_i.imm : id_ex_i.rs2_out;
   assign cmp_b = (id_ex_i.ctrl.opcode == op_br) ? id_ex_i.rs2_out : opb;

   always_comb begin
      case (id_ex_i.ctrl.aluop)
         alu_add: alu_res = opa + opb;
         alu_sll: alu_res = opa << opb[4:0];
         alu_sra: alu_res = rv32i_word'($signed(opa) >>> opb[4:0]);
         alu_sub: alu_res = opa - opb;
         alu_xor: alu_res = opa ^ opb;
         alu_srl: alu_res = opa >> opb[4:0];
         alu_or:  alu_res = opa | opb;
         alu_and: alu_res = opa & opb;
         default: alu_res = '0;
      endcase
   end

   always_comb begin
      case (id_ex_i.ctrl.cmpop)
         beq:     br_en = (id_ex_i.rs1_out == cmp_b);
         bne:     br_en = (id_ex_i.rs1_out != cmp_b);
         blt:     br_en = ($signed(id_ex_i.rs1_out) < $signed(cmp_b));
         bge:     br_en = ($signed(id_ex_i.rs1_out) >= $signed(cmp_b));
         bltu:    br_en = (id_ex_i.rs1_out < cmp_b);
         bgeu:    br_en = (id_ex_i.rs1_out >= cmp_b);
         default: br_en = 1'b0;
      endcase
   end

   // slt and sltu take the compare bit as result
   assign set_less = (id_ex_i.ctrl.opcode inside {op_imm, op_reg}) &&
                     (id_ex_i.instr[14:13] == 2'b01);

   always_comb begin
      ex_mem_o.valid     = id_ex_i.valid;
      ex_mem_o.pc        = id_ex_i.pc;
      ex_mem_o.pc_plus4  = id_ex_i.pc + 32'd4;
      ex_mem_o.ctrl      = id_ex_i.ctrl;
      ex_mem_o.imm       = id_ex_i.imm;
      ex_mem_o.alu_out   = set_less ? {31'd0, br_en} : alu_res;
      ex_mem_o.br_en     = br_en;
      ex_mem_o.rs2_out   = id_ex_i.rs2_out;
      ex_mem_o.br_target = id_ex_i.pc + id_ex_i.imm;
   end

endmodule : rv32i_execute

//--- rv32i_mem_stage.sv
`timescale 1ns/10ps

module rv32i_mem_stage (
   input  logic                  clk,
   input  logic                  rst_i,
   input  rv32i_pkg::ex_mem_t    ex_mem_i,
   output rv32i_pkg::mem_wb_t    mem_wb_o,
   output rv32i_pkg::pcmux_sel_t pcmux_sel_o,
   output rv32i_pkg::rv32i_word  br_target_o,
   output logic                  dmem_read_o,
   output logic                  dmem_write_o,
   output rv32i_pkg::rv32i_word  dmem_addr_o,
   output rv32i_pkg::rv32i_word  dmem_wdata_o
);
   import rv32i_pkg::*;

   logic taken;

   assign taken       = ex_mem_i.valid && ex_mem_i.br_en && (ex_mem_i.ctrl.opcode == op_br);
   assign pcmux_sel_o = pcmux_sel_t'({1'b0, taken});
   assign br_target_o = ex_mem_i.br_target;

   assign dmem_read_o  = ex_mem_i.valid & ex_mem_i.ctrl.mem_read;
   assign dmem_write_o = ex_mem_i.valid & ex_mem_i.ctrl.mem_write;
   assign dmem_wdata_o = ex_mem_i.rs2_out;

   // marmux
   always_comb begin
      case (ex_mem_i.ctrl.marmux_sel)
         marmux_pc:      dmem_addr_o = ex_mem_i.pc;
         marmux_alu_out: dmem_addr_o = ex_mem_i.alu_out;
         default:        dmem_addr_o = ex_mem_i.pc;
      endcase
   end

   always_comb begin
      mem_wb_o.valid    = ex_mem_i.valid;
      mem_wb_o.pc_plus4 = ex_mem_i.pc_plus4;
      mem_wb_o.ctrl     = ex_mem_i.ctrl;
      mem_wb_o.imm      = ex_mem_i.imm;
      mem_wb_o.alu_out  = ex_mem_i.alu_out;
   end

   rd_wr_excl_a: assert property (@(posedge clk) disable iff (rst_i)
      !(dmem_read_o && dmem_write_o));

endmodule : rv32i_mem_stage

//--- rv32i_pkg.sv
package rv32i_pkg;

   typedef logic [31:0] rv32i_word;

   // data memory geometry
   localparam int dmem_words = 256;
   localparam int dmem_aw    = 8;

   typedef enum logic [6:0] {
      op_lui   = 7'b0110111,
      op_auipc = 7'b0010111,
      op_br    = 7'b1100011,
      op_load  = 7'b0000011,
      op_store = 7'b0100011,
      op_imm   = 7'b0010011,
      op_reg   = 7'b0110011
   } rv32i_opcode;

   // encoding lines up with funct3 except for sra and sub
   typedef enum logic [2:0] {
      alu_add = 3'b000,
      alu_sll = 3'b001,
      alu_sra = 3'b010,
      alu_sub = 3'b011,
      alu_xor = 3'b100,
      alu_srl = 3'b101,
      alu_or  = 3'b110,
      alu_and = 3'b111
   } alu_ops;

   typedef enum logic [2:0] {
      beq  = 3'b000,
      bne  = 3'b001,
      blt  = 3'b100,
      bge  = 3'b101,
      bltu = 3'b110,
      bgeu = 3'b111
   } branch_funct3_t;

   typedef enum logic [1:0] {
      pc_plus4 = 2'b00,
      alu_out  = 2'b01
   } pcmux_sel_t;

   // ##########################################################
   // mux select encodings
   localparam logic [1:0] rf_alu_out  = 2'd0;
   localparam logic [1:0] rf_rdata    = 2'd1;
   localparam logic [1:0] rf_pc_plus4 = 2'd2;
   localparam logic [1:0] rf_imm      = 2'd3;

   localparam logic alumux1_rs1    = 1'b0;
   localparam logic alumux1_pc     = 1'b1;
   localparam logic alumux2_rs2    = 1'b0;
   localparam logic alumux2_imm    = 1'b1;
   localparam logic marmux_pc      = 1'b0;
   localparam logic marmux_alu_out = 1'b1;

   // ##########################################################
   // control word and pipeline payloads
   typedef struct packed {
      rv32i_opcode    opcode;
      alu_ops         aluop;
      branch_funct3_t cmpop;
      logic           alumux1_sel;
      logic           alumux2_sel;
      logic           marmux_sel;
      logic           mem_read;
      logic           mem_write;
      logic [1:0]     regfilemux_sel;
      logic           load_regfile;
      logic [4:0]     rd;
   } rv32i_control_word;

   typedef struct packed {
      logic              valid;
      rv32i_word         pc;
      rv32i_word         instr;
      rv32i_control_word ctrl;
      rv32i_word         imm;
      rv32i_word         rs1_out;
      rv32i_word         rs2_out;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      rv32i_word         pc;
      rv32i_word         pc_plus4;
      rv32i_control_word ctrl;
      rv32i_word         imm;
      rv32i_word         alu_out;
      logic              br_en;
      rv32i_word         rs2_out;
      rv32i_word         br_target;
   } ex_mem_t;

   typedef struct packed {
      logic              valid;
      rv32i_word         pc_plus4;
      rv32i_control_word ctrl;
      rv32i_word         imm;
      rv32i_word         alu_out;
   } mem_wb_t;

endpackage : rv32i_pkg

//--- rv32i_regfile.sv
`timescale 1ns/10ps

module rv32i_regfile (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 we_i,
   input  logic [4:0]           rd_i,
   input  rv32i_pkg::rv32i_word rd_data_i,
   input  logic [4:0]           rs1_i,
   input  logic [4:0]           rs2_i,
   output rv32i_pkg::rv32i_word rs1_data_o,
   output rv32i_pkg::rv32i_word rs2_data_o
);
   import rv32i_pkg::*;

   rv32i_word regs [32];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != 5'd0) begin
         regs[rd_i] <= rd_data_i;
      end
   end

   // x0 reads zero, a write in flight is bypassed to the reader
   assign rs1_data_o = (rs1_i == 5'd0) ? '0 :
                       (we_i && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
   assign rs2_data_o = (rs2_i == 5'd0) ? '0 :
                       (we_i && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];

endmodule : rv32i_regfile

//--- rv32i_stage_reg.sv
`timescale 1ns/10ps

module rv32i_stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_i,
   input  payload_t d_i,
   output payload_t q_o
);

   // reset zeroes the whole slot, which leaves a bubble
   always_ff @(posedge clk) begin
      if (rst_i) begin
         q_o <= '0;
      end else begin
         q_o <= d_i;
      end
   end

endmodule : rv32i_stage_reg

//--- rv32i_writeback.sv
`timescale 1ns/10ps

module rv32i_writeback (
   input  logic                 clk,
   input  logic                 rst_i,
   input  rv32i_pkg::mem_wb_t   mem_wb_i,
   input  rv32i_pkg::rv32i_word rdata_i,
   output logic                 we_o,
   output logic [4:0]           rd_o,
   output rv32i_pkg::rv32i_word data_o
);
   import rv32i_pkg::*;

   assign rd_o = mem_wb_i.ctrl.rd;
   assign we_o = mem_wb_i.valid && mem_wb_i.ctrl.load_regfile && (mem_wb_i.ctrl.rd != 5'd0);

   // regfilemux
   always_comb begin
      case (mem_wb_i.ctrl.regfilemux_sel)
         rf_alu_out:  data_o = mem_wb_i.alu_out;
         rf_rdata:    data_o = rdata_i;
         rf_pc_plus4: data_o = mem_wb_i.pc_plus4;
         rf_imm:      data_o = mem_wb_i.imm;
         default:     data_o = mem_wb_i.alu_out;
      endcase
   end

   // a write comes from a valid slot and carries a known value
   wb_valid_a: assert property (@(posedge clk) disable iff (rst_i)
      we_o |-> mem_wb_i.valid && !$isunknown(data_o));

endmodule : rv32i_writeback

//--- tb_rv32i_backend.sv
`timescale 1ns/10ps

module tb_rv32i_backend;
   import rv32i_pkg::*;

   logic       clk;
   logic       rst_i;
   logic       instr_valid_i;
   rv32i_word  instr_i;
   rv32i_word  pc_i;
   pcmux_sel_t pcmux_sel;
   rv32i_word  br_target;
   logic       dmem_write;
   rv32i_word  dmem_addr;
   rv32i_word  dmem_wdata;
   logic       wb_valid;
   logic [4:0] wb_rd;
   rv32i_word  wb_data;

   integer seed;
   int     cycles;
   int     max_cycles;
   int     test_no;
   int     err_mark;
   int     chk_mark;
   int     st_offs [$];

   // test lengths, used for the run limit
   int n_arith    = 40;
   int n_per_cond = 5;
   int n_b2b      = 32;
   int n_stores   = 12;

   rv32i_backend uut (
      .clk           (clk),
      .rst_i         (rst_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .pcmux_sel_o   (pcmux_sel),
      .br_target_o   (br_target),
      .dmem_write_o  (dmem_write),
      .dmem_addr_o   (dmem_addr),
      .dmem_wdata_o  (dmem_wdata),
      .wb_valid_o    (wb_valid),
      .wb_rd_o       (wb_rd),
      .wb_data_o     (wb_data)
   );

   tb_rv32i_checker chk (
      .clk           (clk),
      .rst_i         (rst_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .pcmux_sel_i   (pcmux_sel),
      .br_target_i   (br_target),
      .dmem_write_i  (dmem_write),
      .dmem_addr_i   (dmem_addr),
      .dmem_wdata_i  (dmem_wdata),
      .wb_valid_i    (wb_valid),
      .wb_rd_i       (wb_rd),
      .wb_data_i     (wb_data)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > max_cycles) begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ##########################################################
   // instruction encoding
   function automatic rv32i_word imm_instr(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic rv32i_word reg_instr(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
      return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic rv32i_word upper_instr(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
      return {imm, rd, opc};
   endfunction

   function automatic rv32i_word branch_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic rv32i_word store_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic rv32i_word load_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, 3'b010, rd, 7'b0000011};
   endfunction

   // lui, auipc, op_imm or op_reg with the given registers
   function automatic rv32i_word random_alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [4:0] rs2);
      int         kind;
      logic [2:0] f3;
      logic       alt;
      logic [11:0] imm;
      rv32i_word  rnd;
      kind = {$random(seed)} % 8;
      f3   = $random(seed);
      alt  = $random(seed);
      imm  = $random(seed);
      rnd  = $random(seed);
      if (kind == 0) begin
         return upper_instr(op_lui, rd, rnd[19:0]);
      end else if (kind == 1) begin
         return upper_instr(op_auipc, rd, rnd[19:0]);
      end else if (kind < 5) begin
         if (f3 == 3'b001) begin
            imm = {7'd0, imm[4:0]};
         end else if (f3 == 3'b101) begin
            imm = {1'b0, alt, 5'd0, imm[4:0]};
         end
         return imm_instr(f3, rd, rs1, imm);
      end
      if (f3 != 3'b000 && f3 != 3'b101) begin
         alt = 1'b0;
      end
      return reg_instr(f3, alt, rd, rs1, rs2);
   endfunction

   // ##########################################################
   // stimulus
   task automatic issue(input rv32i_word instr, input int gap);
      rv32i_word rnd;
      @(posedge clk);
      #2;
      rnd           = $random(seed);
      instr_valid_i = 1'b1;
      instr_i       = instr;
      pc_i          = {16'd0, rnd[15:2], 2'b00};
      repeat (gap) begin
         @(posedge clk);
         #2;
         instr_valid_i = 1'b0;
         instr_i       = '0;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         instr_valid_i = 1'b0;
         instr_i       = '0;
      end
   endtask

   task automatic close_test(input string name);
      int errs;
      int chks;
      errs     = chk.err_cnt - err_mark;
      chks     = chk.chk_cnt - chk_mark;
      test_no  = test_no + 1;
      $display("test %0d %s: %0d checks, %0d errors", test_no, name, chks, errs);
      err_mark = chk.err_cnt;
      chk_mark = chk.chk_cnt;
   endtask

   initial begin
      logic [2:0]  conds [6];
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [12:0] bimm;
      rv32i_word   rnd;
      int          off;
      seed          = 33891;
      cycles        = 0;
      test_no       = 0;
      err_mark      = 0;
      chk_mark      = 0;
      clk           = 1'b0;
      rst_i         = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      pc_i          = '0;
      conds         = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      // three slots per instruction with bubbles, four idle cycles per test
      max_cycles = 2 + 5 + 30 * 3 + n_arith * 3 + (n_stores + 1) * 3 + n_stores * 3
                   + 6 * n_per_cond * 3 + n_b2b + 6 * 4 + 20;

      repeat (2) @(posedge clk);
      #2;
      rst_i = 1'b0;

      idle(5);
      close_test("reset");

      // seed x1..x15 with random values, then random ALU traffic
      for (int r = 1; r < 16; r++) begin
         rnd = $random(seed);
         issue(upper_instr(op_lui, r[4:0], rnd[31:12]), 2);
         issue(imm_instr(3'b000, r[4:0], r[4:0], rnd[11:0]), 2);
      end
      for (int i = 0; i < n_arith; i++) begin
         issue(random_alu_instr($random(seed), $random(seed), $random(seed)), 2);
      end
      idle(4);
      close_test("arithmetic");

      // x5 is the base register for memory traffic
      issue(imm_instr(3'b000, 5'd5, 5'd0, 12'd256), 2);
      for (int i = 0; i < n_stores; i++) begin
         off = ({$random(seed)} % 256) * 4 - 256;
         st_offs.push_back(off);
         issue(store_instr(5'd1 + ({$random(seed)} % 31), 5'd5, off[11:0]), 2);
      end
      idle(4);
      close_test("stores");

      foreach (st_offs[i]) begin
         off = st_offs[i];
         issue(load_instr(5'd6 + ({$random(seed)} % 26), 5'd5, off[11:0]), 2);
      end
      idle(4);
      close_test("loads");

      for (int c = 0; c < 6; c++) begin
         for (int k = 0; k < n_per_cond; k++) begin
            ra   = 5'd1 + ({$random(seed)} % 15);
            rb   = (k == 0) ? ra : 5'd1 + ({$random(seed)} % 15);
            bimm = $random(seed);
            bimm[0] = 1'b0;
            issue(branch_instr(conds[c], ra, rb, bimm), 2);
         end
      end
      idle(4);
      close_test("branches");

      // destinations x16..x31, sources x1..x15, so no slot depends on another
      for (int k = 0; k < n_b2b; k++) begin
         issue(random_alu_instr(5'd16 + (k % 16), 5'd1 + ({$random(seed)} % 15),
                                5'd1 + ({$random(seed)} % 15)), 0);
      end
      idle(4);
      close_test("back to back");

      chk.report_pending();
      $display("tests %0d, checks %0d, errors %0d", test_no, chk.chk_cnt, chk.err_cnt);
      if (chk.err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule : tb_rv32i_backend

//--- tb_rv32i_checker.sv
`timescale 1ns/10ps

module tb_rv32i_checker (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  instr_valid_i,
   input  rv32i_pkg::rv32i_word  instr_i,
   input  rv32i_pkg::rv32i_word  pc_i,
   input  rv32i_pkg::pcmux_sel_t pcmux_sel_i,
   input  rv32i_pkg::rv32i_word  br_target_i,
   input  logic                  dmem_write_i,
   input  rv32i_pkg::rv32i_word  dmem_addr_i,
   input  rv32i_pkg::rv32i_word  dmem_wdata_i,
   input  logic                  wb_valid_i,
   input  logic [4:0]            wb_rd_i,
   input  rv32i_pkg::rv32i_word  wb_data_i
);
   import rv32i_pkg::*;

   typedef struct packed {
      logic       we;
      logic [4:0] rd;
      rv32i_word  data;
      logic       st;
      rv32i_word  addr;
      rv32i_word  wdata;
      logic       br;
      logic       taken;
      rv32i_word  target;
   } outcome_t;

   typedef struct packed {
      int       due;
      outcome_t exp;
   } pend_t;

   rv32i_word xreg [32];
   rv32i_word mmem [dmem_words];
   pend_t     mem_q [$];
   pend_t     wb_q [$];
   int        cyc;
   int        err_cnt;
   int        chk_cnt;

   initial begin
      cyc     = 0;
      err_cnt = 0;
      chk_cnt = 0;
      for (int i = 0; i < 32; i++) begin
         xreg[i] = '0;
      end
      for (int i = 0; i < dmem_words; i++) begin
         mmem[i] = '0;
      end
   end

   // ##########################################################
   // reference model, straight from the RV32I rules
   function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                         input rv32i_word x, input rv32i_word y);
      rv32i_word r;
      case (f3)
         3'b000: r = alt ? x - y : x + y;
         3'b001: r = x << y[4:0];
         3'b010: r = {31'd0, $signed(x) < $signed(y)};
         3'b011: r = {31'd0, x < y};
         3'b100: r = x ^ y;
         3'b101: begin
            if (alt) begin
               r = $signed(x) >>> y[4:0];
            end else begin
               r = x >> y[4:0];
            end
         end
         3'b110: r = x | y;
         default: r = x & y;
      endcase
      return r;
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input rv32i_word x,
                                       input rv32i_word y);
      case (f3)
         3'b000: return x == y;
         3'b001: return x != y;
         3'b100: return $signed(x) < $signed(y);
         3'b101: return $signed(x) >= $signed(y);
         3'b110: return x < y;
         default: return x >= y;
      endcase
   endfunction

   function automatic outcome_t predict(input rv32i_word ins, input rv32i_word pc);
      outcome_t  o;
      logic [2:0] f3;
      rv32i_word a;
      rv32i_word b;
      rv32i_word ii;
      rv32i_word si;
      rv32i_word bi;
      rv32i_word ui;
      rv32i_word ea;
      o  = '0;
      f3 = ins[14:12];
      a  = xreg[ins[19:15]];
      b  = xreg[ins[24:20]];
      ii = {{20{ins[31]}}, ins[31:20]};
      si = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      bi = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      ui = {ins[31:12], 12'h000};
      o.rd = ins[11:7];
      case (ins[6:0])
         7'b0110111: begin
            o.we   = 1'b1;
            o.data = ui;
         end
         7'b0010111: begin
            o.we   = 1'b1;
            o.data = pc + ui;
         end
         7'b0010011: begin
            o.we   = 1'b1;
            o.data = alu_ref(f3, (f3 == 3'b101) && ins[30], a, ii);
         end
         7'b0110011: begin
            o.we   = 1'b1;
            o.data = alu_ref(f3, ins[30], a, b);
         end
         7'b1100011: begin
            o.br     = 1'b1;
            o.taken  = branch_ref(f3, a, b);
            o.target = pc + bi;
         end
         7'b0100011: begin
            o.st    = 1'b1;
            o.addr  = a + si;
            o.wdata = b;
         end
         default: begin
            // lw
            ea     = a + ii;
            o.we   = 1'b1;
            o.data = mmem[ea[dmem_aw+1:2]];
         end
      endcase
      if (o.rd == 5'd0) begin
         o.we = 1'b0;
      end
      return o;
   endfunction

   // ##########################################################
   // reporting
   task automatic compare_word(input string name, input rv32i_word exp, input rv32i_word act);
      chk_cnt++;
      if (exp !== act) begin
         err_cnt++;
         $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      err_cnt++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   task automatic report_pending();
      if (wb_q.size() > 0 || mem_q.size() > 0) begin
         report_error($sformatf("%0d issued instructions never produced their outcome",
                                wb_q.size()));
      end
   endtask

   // capture each accepted instruction with its expected outcome
   always @(posedge clk) begin
      pend_t p;
      cyc = cyc + 1;
      if (!rst_i && instr_valid_i) begin
         p.exp = predict(instr_i, pc_i);
         if (p.exp.we) begin
            xreg[p.exp.rd] = p.exp.data;
         end
         if (p.exp.st) begin
            mmem[p.exp.addr[dmem_aw+1:2]] = p.exp.wdata;
         end
         p.due = cyc + 1;
         mem_q.push_back(p);
         p.due = cyc + 2;
         wb_q.push_back(p);
      end
   end

   // outputs are settled by mid cycle
   always @(negedge clk) begin
      pend_t e;
      if (!rst_i) begin
         if (mem_q.size() > 0 && mem_q[0].due == cyc) begin
            e = mem_q.pop_front();
            compare_word("dmem_write_o", {31'd0, e.exp.st}, {31'd0, dmem_write_i});
            if (e.exp.st) begin
               compare_word("dmem_addr_o", e.exp.addr, dmem_addr_i);
               compare_word("dmem_wdata_o", e.exp.wdata, dmem_wdata_i);
            end
            compare_word("pcmux_sel_o", {30'd0, e.exp.taken ? alu_out : pc_plus4},
                         {30'd0, pcmux_sel_i});
            if (e.exp.br) begin
               compare_word("br_target_o", e.exp.target, br_target_i);
            end
         end else begin
            compare_word("dmem_write_o", 32'd0, {31'd0, dmem_write_i});
            compare_word("pcmux_sel_o", {30'd0, pc_plus4}, {30'd0, pcmux_sel_i});
         end
         if (wb_q.size() > 0 && wb_q[0].due == cyc) begin
            e = wb_q.pop_front();
            compare_word("wb_valid_o", {31'd0, e.exp.we}, {31'd0, wb_valid_i});
            if (e.exp.we) begin
               compare_word("wb_rd_o", {27'd0, e.exp.rd}, {27'd0, wb_rd_i});
               compare_word("wb_data_o", e.exp.data, wb_data_i);
            end
         end else if (wb_valid_i) begin
            report_error($sformatf("writeback to x%0d with no instruction queued", wb_rd_i));
         end
      end
   end

endmodule : tb_rv32i_checker
